//--- rtl/mem_bus_pkg.sv
package mem_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;

  // default mtime location of the CLINT
  localparam addr_t MTIME_ADDR = 32'h0200_BFF8;

  // AXI transfer size, bytes per beat as a power of two
  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } axi_size_e;

  // bus owner and phase
  typedef enum logic [2:0] {
    arb_idle  = 3'd0,
    arb_if_ar = 3'd1,
    arb_if_r  = 3'd2,
    arb_ls_ar = 3'd3,
    arb_ls_r  = 3'd4,
    arb_ls_w  = 3'd5,
    arb_ls_b  = 3'd6
  } arb_state_e;

  typedef struct packed {
    addr_t       addr;
    axi_size_e   size;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic [3:0]  id;
  } axi_ar_t;

  typedef struct packed {
    addr_t       addr;
    axi_size_e   size;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic [3:0]  id;
  } axi_aw_t;

  typedef struct packed {
    beat_t       data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    beat_t       data;
    logic [1:0]  resp;
    logic        last;
    logic [3:0]  id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0]  resp;
    logic [3:0]  id;
  } axi_b_t;

  typedef struct packed {
    addr_t       addr;
    logic [3:0]  strb;
  } ld_req_t;

  typedef struct packed {
    addr_t       addr;
    word_t       data;
    logic [3:0]  strb;
  } st_req_t;

  // core strobe 1, 3 or F to the matching AXI size
  function automatic axi_size_e strb_to_size(input logic [3:0] strb);
    case (strb)
      4'hF:    return size_word;
      4'h3:    return size_half;
      default: return size_byte;
    endcase
  endfunction

endpackage

//--- rtl/bus_arbiter.sv
module bus_arbiter import mem_bus_pkg::*; #(
  parameter addr_t CLINT_BASE = MTIME_ADDR
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  if_req_i,
  input  logic  ld_req_i,
  input  logic  st_req_i,
  input  addr_t ld_addr_i,
  input  logic  ar_ready_i,
  input  logic  aw_ready_i,
  input  logic  w_ready_i,
  input  logic  r_valid_i,
  input  logic  b_valid_i,
  output logic  ar_valid_o,
  output logic  aw_valid_o,
  output logic  w_valid_o,
  output logic  rd_sel_o,
  output logic  clint_rd_o,
  output logic  if_done_o,
  output logic  ld_done_o,
  output logic  st_done_o
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       aw_done_q;
  logic       w_done_q;
  logic       if_served_q;
  logic       ld_served_q;
  logic       st_served_q;
  logic       clint_rd_q;
  logic       clint_hit;
  logic       if_pend;
  logic       ld_pend;
  logic       st_pend;
  logic       if_grant;
  logic       ld_grant;
  logic       st_grant;
  logic       aw_fire;
  logic       w_fire;

  // mtime low or high word
  assign clint_hit = (ld_addr_i == CLINT_BASE) || (ld_addr_i == CLINT_BASE + 32'd4);

  // a served request must drop before it counts again
  assign if_pend = if_req_i & ~if_served_q;
  assign ld_pend = ld_req_i & ~ld_served_q;
  assign st_pend = st_req_i & ~st_served_q;

  // load first, then store, then fetch
  assign ld_grant = (state_q == arb_idle) & ld_pend;
  assign st_grant = (state_q == arb_idle) & ~ld_pend & st_pend;
  assign if_grant = (state_q == arb_idle) & ~ld_pend & ~st_pend & if_pend;

  assign ar_valid_o = (state_q == arb_if_ar) | (state_q == arb_ls_ar);
  assign aw_valid_o = (state_q == arb_ls_w) & ~aw_done_q;
  assign w_valid_o  = (state_q == arb_ls_w) & ~w_done_q;
  assign rd_sel_o   = (state_q == arb_ls_ar) | (state_q == arb_ls_r);
  assign clint_rd_o = clint_rd_q;

  assign aw_fire = aw_valid_o & aw_ready_i;
  assign w_fire  = w_valid_o & w_ready_i;

  // completion pulses follow the owner's response valid
  assign if_done_o = (state_q == arb_if_r) & r_valid_i;
  assign ld_done_o = (state_q == arb_ls_r) & r_valid_i;
  assign st_done_o = (state_q == arb_ls_b) & b_valid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      arb_idle:
      begin
        // CLINT loads stay off the bus
        if (ld_grant && !clint_hit)
          state_d = arb_ls_ar;
        else if (st_grant)
          state_d = arb_ls_w;
        else if (if_grant)
          state_d = arb_if_ar;
      end
      arb_if_ar:
        if (ar_ready_i)
          state_d = arb_if_r;
      arb_if_r:
        if (r_valid_i)
          state_d = arb_idle;
      arb_ls_ar:
        if (ar_ready_i)
          state_d = arb_ls_r;
      arb_ls_r:
        if (r_valid_i)
          state_d = arb_idle;
      arb_ls_w:
        // aw and w may be taken in either order
        if ((aw_done_q | aw_fire) && (w_done_q | w_fire))
          state_d = arb_ls_b;
      arb_ls_b:
        if (b_valid_i)
          state_d = arb_idle;
      default:
        state_d = arb_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= arb_idle;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      if_served_q <= 1'b0;
      ld_served_q <= 1'b0;
      st_served_q <= 1'b0;
      clint_rd_q  <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      clint_rd_q <= ld_grant & clint_hit;
      if (state_d == arb_ls_b || state_q != arb_ls_w)
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
      else
      begin
        aw_done_q <= aw_done_q | aw_fire;
        w_done_q  <= w_done_q | w_fire;
      end
      if_served_q <= if_req_i & (if_served_q | if_grant);
      ld_served_q <= ld_req_i & (ld_served_q | ld_grant);
      st_served_q <= st_req_i & (st_served_q | st_grant);
    end
  end

endmodule

//--- rtl/store_align.sv
module store_align import mem_bus_pkg::*; (
  input  st_req_t st_i,
  output axi_aw_t aw_o,
  output axi_w_t  w_o
);

  logic [1:0] byte_off;
  word_t      data_sh;
  logic [3:0] strb_sh;
  logic [7:0] half_mask;

  assign byte_off = st_i.addr[1:0];

  // move the store to its byte position inside the word
  always_comb
  begin
    data_sh = st_i.data << {byte_off, 3'b000};
    strb_sh = st_i.strb << byte_off;
  end

  // bit 2 picks which half of the beat is written
  assign half_mask = st_i.addr[2] ? 8'hF0 : 8'h0F;

  always_comb
  begin
    aw_o.addr  = st_i.addr;
    aw_o.size  = strb_to_size(st_i.strb);
    // single beat, ID 0
    aw_o.len   = 8'd0;
    aw_o.burst = 2'b00;
    aw_o.id    = 4'd0;
  end

  always_comb
  begin
    // same word on both halves, strobe decides
    w_o.data = {data_sh, data_sh};
    w_o.strb = {strb_sh, strb_sh} & half_mask;
    w_o.last = 1'b1;
  end

endmodule

//--- rtl/load_return.sv
module load_return import mem_bus_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  addr_t   if_addr_i,
  input  ld_req_t ld_i,
  input  logic    rd_sel_i,
  input  logic    ld_done_i,
  input  axi_r_t  r_i,
  input  word_t   clint_data_i,
  input  logic    clint_valid_i,
  output axi_ar_t ar_o,
  output word_t   if_rdata_o,
  output word_t   ld_rdata_o,
  output logic    ld_rvalid_o
);

  logic  lane_hi_q;
  word_t lane_word;

  // the read channel carries whichever port owns it
  always_comb
  begin
    ar_o.addr  = rd_sel_i ? ld_i.addr : if_addr_i;
    ar_o.size  = rd_sel_i ? strb_to_size(ld_i.strb) : size_word;
    ar_o.len   = 8'd0;
    ar_o.burst = 2'b00;
    ar_o.id    = 4'd0;
  end

  // address is held by the core, so this stays valid into the data phase
  always_ff @(posedge clk)
  begin
    if (rst)
      lane_hi_q <= 1'b0;
    else
      lane_hi_q <= ar_o.addr[2];
  end

  assign lane_word = lane_hi_q ? r_i.data[63:32] : r_i.data[31:0];

  assign if_rdata_o = lane_word;

  // timer reads take over the load path
  assign ld_rdata_o  = clint_valid_i ? clint_data_i : lane_word;
  assign ld_rvalid_o = ld_done_i | clint_valid_i;

endmodule

//--- rtl/clint_timer.sv
module clint_timer import mem_bus_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_i,
  input  logic  addr_hi_i,
  output word_t rdata_o,
  output logic  rvalid_o
);

  logic [63:0] mtime_q;
  word_t       rdata_q;
  logic        rvalid_q;

  // free-running, one tick per clock
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_q <= 1'b0;
    else
      rvalid_q <= rd_i;
  end

  // captured word, only meaningful with rvalid
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= addr_hi_i ? mtime_q[63:32] : mtime_q[31:0];
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

//--- rtl/mem_bus_top.sv
module mem_bus_top import mem_bus_pkg::*; #(
  parameter addr_t CLINT_BASE = MTIME_ADDR
) (
  input  logic    clk,
  input  logic    rst,

  // fetch port
  input  logic    if_req_i,
  input  addr_t   if_addr_i,
  output word_t   if_rdata_o,
  output logic    if_rvalid_o,

  // load port
  input  logic    ld_req_i,
  input  ld_req_t ld_i,
  output word_t   ld_rdata_o,
  output logic    ld_rvalid_o,

  // store port
  input  logic    st_req_i,
  input  st_req_t st_i,
  output logic    st_done_o,

  // AXI4 master
  output axi_ar_t ar_o,
  output logic    ar_valid_o,
  input  logic    ar_ready_i,
  input  axi_r_t  r_i,
  input  logic    r_valid_i,
  output logic    r_ready_o,
  output axi_aw_t aw_o,
  output logic    aw_valid_o,
  input  logic    aw_ready_i,
  output axi_w_t  w_o,
  output logic    w_valid_o,
  input  logic    w_ready_i,
  input  axi_b_t  b_i,
  input  logic    b_valid_i,
  output logic    b_ready_o
);

  logic  rd_sel;
  logic  clint_rd;
  logic  ld_done;
  word_t clint_data;
  logic  clint_valid;

  // responses are always accepted
  assign r_ready_o = 1'b1;
  assign b_ready_o = 1'b1;

  bus_arbiter #(
    .CLINT_BASE (CLINT_BASE)
  ) arbiter_i (
    .clk        (clk),
    .rst        (rst),
    .if_req_i   (if_req_i),
    .ld_req_i   (ld_req_i),
    .st_req_i   (st_req_i),
    .ld_addr_i  (ld_i.addr),
    .ar_ready_i (ar_ready_i),
    .aw_ready_i (aw_ready_i),
    .w_ready_i  (w_ready_i),
    .r_valid_i  (r_valid_i),
    .b_valid_i  (b_valid_i),
    .ar_valid_o (ar_valid_o),
    .aw_valid_o (aw_valid_o),
    .w_valid_o  (w_valid_o),
    .rd_sel_o   (rd_sel),
    .clint_rd_o (clint_rd),
    .if_done_o  (if_rvalid_o),
    .ld_done_o  (ld_done),
    .st_done_o  (st_done_o)
  );

  store_align store_i (
    .st_i (st_i),
    .aw_o (aw_o),
    .w_o  (w_o)
  );

  load_return load_i (
    .clk           (clk),
    .rst           (rst),
    .if_addr_i     (if_addr_i),
    .ld_i          (ld_i),
    .rd_sel_i      (rd_sel),
    .ld_done_i     (ld_done),
    .r_i           (r_i),
    .clint_data_i  (clint_data),
    .clint_valid_i (clint_valid),
    .ar_o          (ar_o),
    .if_rdata_o    (if_rdata_o),
    .ld_rdata_o    (ld_rdata_o),
    .ld_rvalid_o   (ld_rvalid_o)
  );

  clint_timer clint_i (
    .clk       (clk),
    .rst       (rst),
    .rd_i      (clint_rd),
    .addr_hi_i (ld_i.addr[2]),
    .rdata_o   (clint_data),
    .rvalid_o  (clint_valid)
  );

endmodule

//--- test/mem_bus_sva.sv
module mem_bus_sva import mem_bus_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   ar_valid_i,
  input logic   ar_ready_i,
  input logic   aw_valid_i,
  input logic   aw_ready_i,
  input logic   w_valid_i,
  input logic   w_ready_i,
  input logic   r_valid_i,
  input axi_r_t r_i,
  input logic   b_valid_i,
  input axi_b_t b_i,
  input logic   if_rvalid_i,
  input logic   ld_rvalid_i,
  input logic   st_done_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions so far
  int unsigned fail_cnt = 0;

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid_i && !ar_ready_i |=> ar_valid_i)
    else
    begin
      fail_cnt++;
      $error("ar_valid dropped before ar_ready");
    end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    aw_valid_i && !aw_ready_i |=> aw_valid_i)
    else
    begin
      fail_cnt++;
      $error("aw_valid dropped before aw_ready");
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    w_valid_i && !w_ready_i |=> w_valid_i)
    else
    begin
      fail_cnt++;
      $error("w_valid dropped before w_ready");
    end

  // one address channel at a time
  rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(ar_valid_i && aw_valid_i))
    else
    begin
      fail_cnt++;
      $error("ar_valid and aw_valid high together");
    end

  done_excl: assert property (@(posedge clk) disable iff (rst)
    $onehot0({if_rvalid_i, ld_rvalid_i, st_done_i}))
    else
    begin
      fail_cnt++;
      $error("more than one completion pulse in a cycle");
    end

  r_okay: assert property (@(posedge clk) disable iff (rst)
    r_valid_i |-> r_i.resp == 2'b00)
    else
    begin
      fail_cnt++;
      $error("read response is not OKAY");
    end

  b_okay: assert property (@(posedge clk) disable iff (rst)
    b_valid_i |-> b_i.resp == 2'b00)
    else
    begin
      fail_cnt++;
      $error("write response is not OKAY");
    end

endmodule

//--- test/mem_bus_tb.sv
module mem_bus_tb import mem_bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {
    op_fetch,
    op_load,
    op_store,
    op_clint
  } op_e;

  typedef struct packed {
    op_e        op;
    addr_t      addr;
    word_t      data;
    logic [3:0] strb;
    word_t      exp;
    axi_size_e  size;
  } entry_t;

  localparam int ENTRIES = 24;
  // three extra requests for the arbitration race
  localparam int TIMEOUT = (ENTRIES + 3) * 40 + 16;

  // slave memory is preloaded with addr ^ 5A5A0000 per word
  entry_t stim [ENTRIES] = '{
    '{op_fetch, 32'h0000_0100, 32'h0000_0000, 4'hF, 32'h5A5A_0100, size_word},
    '{op_fetch, 32'h0000_0104, 32'h0000_0000, 4'hF, 32'h5A5A_0104, size_word},
    '{op_fetch, 32'h0000_07FC, 32'h0000_0000, 4'hF, 32'h5A5A_07FC, size_word},
    '{op_fetch, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h5A5A_0010, size_word},
    '{op_store, 32'h0000_0201, 32'h0000_00C7, 4'h1, 32'h0000_0000, size_byte},
    '{op_load,  32'h0000_0200, 32'h0000_0000, 4'hF, 32'h5A5A_C700, size_word},
    '{op_store, 32'h0000_020E, 32'h0000_BEEF, 4'h3, 32'h0000_0000, size_half},
    '{op_load,  32'h0000_020C, 32'h0000_0000, 4'hF, 32'hBEEF_020C, size_word},
    '{op_store, 32'h0000_0318, 32'h1234_5678, 4'hF, 32'h0000_0000, size_word},
    '{op_load,  32'h0000_0318, 32'h0000_0000, 4'hF, 32'h1234_5678, size_word},
    '{op_store, 32'h0000_031F, 32'h0000_0099, 4'h1, 32'h0000_0000, size_byte},
    '{op_load,  32'h0000_031C, 32'h0000_0000, 4'hF, 32'h995A_031C, size_word},
    '{op_load,  32'h0000_0318, 32'h0000_0000, 4'hF, 32'h1234_5678, size_word},
    '{op_clint, MTIME_ADDR,    32'h0000_0000, 4'hF, 32'h0000_0000, size_word},
    '{op_clint, MTIME_ADDR,    32'h0000_0000, 4'hF, 32'h0000_0000, size_word},
    '{op_clint, MTIME_ADDR + 4, 32'h0000_0000, 4'hF, 32'h0000_0000, size_word},
    '{op_store, 32'h0000_0404, 32'hFFFF_1357, 4'h3, 32'h0000_0000, size_half},
    '{op_load,  32'h0000_0404, 32'h0000_0000, 4'hF, 32'h5A5A_1357, size_word},
    '{op_fetch, 32'h0000_0404, 32'h0000_0000, 4'hF, 32'h5A5A_1357, size_word},
    '{op_store, 32'h0000_0402, 32'hAAAA_AA3C, 4'h1, 32'h0000_0000, size_byte},
    '{op_load,  32'h0000_0400, 32'h0000_0000, 4'hF, 32'h5A3C_0400, size_word},
    '{op_clint, MTIME_ADDR,    32'h0000_0000, 4'hF, 32'h0000_0000, size_word},
    '{op_fetch, 32'h0000_07F8, 32'h0000_0000, 4'hF, 32'h5A5A_07F8, size_word},
    '{op_load,  32'h0000_0000, 32'h0000_0000, 4'hF, 32'h5A5A_0000, size_word}
  };

  logic    clk = 1'b0;
  logic    rst;
  logic    if_req_i;
  addr_t   if_addr_i;
  word_t   if_rdata_o;
  logic    if_rvalid_o;
  logic    ld_req_i;
  ld_req_t ld_i;
  word_t   ld_rdata_o;
  logic    ld_rvalid_o;
  logic    st_req_i;
  st_req_t st_i;
  logic    st_done_o;
  axi_ar_t ar_o;
  logic    ar_valid_o;
  logic    ar_ready_i;
  axi_r_t  r_i;
  logic    r_valid_i;
  logic    r_ready_o;
  axi_aw_t aw_o;
  logic    aw_valid_o;
  logic    aw_ready_i;
  axi_w_t  w_o;
  logic    w_valid_o;
  logic    w_ready_i;
  axi_b_t  b_i;
  logic    b_valid_i;
  logic    b_ready_o;

  beat_t       mem_q [256];
  axi_size_e   last_ar_size;
  axi_size_e   last_aw_size;
  word_t       clint_last;
  logic        clint_seen = 1'b0;
  int unsigned cycle_cnt = 0;
  int unsigned if_cnt = 0;
  int unsigned ld_cnt = 0;
  int unsigned st_cnt = 0;
  int unsigned exp_if = 0;
  int unsigned exp_ld = 0;
  int unsigned exp_st = 0;

  mem_bus_top dut_i (.*);

  bind mem_bus_top mem_bus_sva sva_i (
    .clk         (clk),
    .rst         (rst),
    .ar_valid_i  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .aw_valid_i  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .w_valid_i   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .r_valid_i   (r_valid_i),
    .r_i         (r_i),
    .b_valid_i   (b_valid_i),
    .b_i         (b_i),
    .if_rvalid_i (if_rvalid_o),
    .ld_rvalid_i (ld_rvalid_o),
    .st_done_i   (st_done_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT)
      abort_run($sformatf("run stalled: no completion within %0d cycles", TIMEOUT));
  end

  // a failed bus assertion ends the run
  always @(posedge clk)
  begin
    if (dut_i.sva_i.fail_cnt != 0)
      abort_run("an AXI protocol assertion failed");
  end

  // completion pulses, compared with the requests at the end
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if_cnt += if_rvalid_o;
      ld_cnt += ld_rvalid_o;
      st_cnt += st_done_o;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_size(input string name, input axi_size_e got, input axi_size_e exp);
    if (got !== exp)
      abort_run($sformatf("mismatch at %0d ns: %s = %s, expected %s",
                          $time, name, got.name(), exp.name()));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("mismatch at %0d ns: %s = %0d, expected %0d", $time, name, got, exp));
  endtask

  // one beat per read, random waits before ready and rvalid
  task automatic serve_reads();
    addr_t rd_addr;
    forever
    begin
      @(posedge clk);
      if (!rst && ar_valid_o)
      begin
        rd_addr = ar_o.addr;
        last_ar_size = ar_o.size;
        repeat ($urandom_range(3)) @(posedge clk);
        ar_ready_i <= 1'b1;
        @(posedge clk);
        ar_ready_i <= 1'b0;
        repeat ($urandom_range(3)) @(posedge clk);
        r_i <= '{data: mem_q[rd_addr[10:3]], resp: 2'b00, last: 1'b1, id: 4'd0};
        r_valid_i <= 1'b1;
        @(posedge clk);
        if (!r_ready_o)
          abort_run("r_ready_o was low while read data was offered");
        r_valid_i <= 1'b0;
      end
    end
  endtask

  // aw and w accepted independently, then the strobed merge
  task automatic serve_writes();
    addr_t       wr_addr;
    beat_t       wr_data;
    logic [7:0]  wr_strb;
    int unsigned aw_left;
    int unsigned w_left;
    logic        aw_seen;
    logic        w_seen;
    forever
    begin
      @(posedge clk);
      if (!rst && aw_valid_o && w_valid_o)
      begin
        wr_addr = aw_o.addr;
        wr_data = w_o.data;
        wr_strb = w_o.strb;
        last_aw_size = aw_o.size;
        aw_left = $urandom_range(3);
        w_left = $urandom_range(3);
        aw_seen = 1'b0;
        w_seen = 1'b0;
        while (!(aw_seen && w_seen))
        begin
          aw_ready_i <= !aw_seen && aw_left == 0;
          w_ready_i <= !w_seen && w_left == 0;
          @(posedge clk);
          aw_seen = aw_seen | aw_ready_i;
          w_seen = w_seen | w_ready_i;
          aw_left = (aw_left != 0) ? aw_left - 1 : 0;
          w_left = (w_left != 0) ? w_left - 1 : 0;
        end
        aw_ready_i <= 1'b0;
        w_ready_i <= 1'b0;
        for (int b = 0; b < 8; b++)
        begin
          if (wr_strb[b])
            mem_q[wr_addr[10:3]][b*8 +: 8] = wr_data[b*8 +: 8];
        end
        repeat ($urandom_range(3)) @(posedge clk);
        b_i <= '{resp: 2'b00, id: 4'd0};
        b_valid_i <= 1'b1;
        @(posedge clk);
        if (!b_ready_o)
          abort_run("b_ready_o was low while the write response was offered");
        b_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    int   edges;
    logic done;
    @(posedge clk);
    case (e.op)
      op_fetch:
      begin
        if_req_i <= 1'b1;
        if_addr_i <= e.addr;
      end
      op_store:
      begin
        st_req_i <= 1'b1;
        st_i <= '{addr: e.addr, data: e.data, strb: e.strb};
      end
      default:
      begin
        ld_req_i <= 1'b1;
        ld_i <= '{addr: e.addr, strb: e.strb};
      end
    endcase
    edges = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      edges++;
      if (e.op == op_clint && ar_valid_o)
        abort_run("ar_valid raised during a CLINT load");
      done = (e.op == op_fetch) ? if_rvalid_o : (e.op == op_store) ? st_done_o : ld_rvalid_o;
    end
    case (e.op)
      op_fetch:
      begin
        check_word("if_rdata_o", if_rdata_o, e.exp);
        check_size("ar_o.size", last_ar_size, e.size);
        exp_if++;
      end
      op_load:
      begin
        check_word("ld_rdata_o", ld_rdata_o, e.exp);
        check_size("ar_o.size", last_ar_size, e.size);
        exp_ld++;
      end
      op_store:
      begin
        check_size("aw_o.size", last_aw_size, e.size);
        exp_st++;
      end
      default:
      begin
        // request cycle to pulse cycle
        check_count("CLINT load latency", edges - 1, 2);
        if (e.addr[2])
          check_word("ld_rdata_o", ld_rdata_o, e.exp);
        else
        begin
          if (clint_seen && ld_rdata_o <= clint_last)
            abort_run($sformatf("mtime low word did not increase: %h after %h",
                                ld_rdata_o, clint_last));
          clint_last = ld_rdata_o;
          clint_seen = 1'b1;
        end
        exp_ld++;
      end
    endcase
    if_req_i <= 1'b0;
    ld_req_i <= 1'b0;
    st_req_i <= 1'b0;
  endtask

  // load, store and fetch raised together, served in that order
  task automatic race_requests();
    logic ld_seen;
    logic st_seen;
    logic if_seen;
    @(posedge clk);
    ld_req_i <= 1'b1;
    ld_i <= '{addr: 32'h0000_0104, strb: 4'hF};
    st_req_i <= 1'b1;
    st_i <= '{addr: 32'h0000_0500, data: 32'h0BAD_F00D, strb: 4'hF};
    if_req_i <= 1'b1;
    if_addr_i <= 32'h0000_0100;
    ld_seen = 1'b0;
    st_seen = 1'b0;
    if_seen = 1'b0;
    while (!(ld_seen && st_seen && if_seen))
    begin
      @(posedge clk);
      if (if_rvalid_o)
      begin
        if (!st_seen)
          abort_run("fetch completed before the load and store requested with it");
        check_word("if_rdata_o", if_rdata_o, 32'h5A5A_0100);
        if_seen = 1'b1;
        if_req_i <= 1'b0;
      end
      if (st_done_o)
      begin
        if (!ld_seen)
          abort_run("store completed before the load requested with it");
        st_seen = 1'b1;
        st_req_i <= 1'b0;
      end
      if (ld_rvalid_o)
      begin
        check_word("ld_rdata_o", ld_rdata_o, 32'h5A5A_0104);
        ld_seen = 1'b1;
        ld_req_i <= 1'b0;
      end
    end
    exp_ld++;
    exp_st++;
    exp_if++;
  endtask

  initial
  begin
    rst = 1'b1;
    if_req_i = 1'b0;
    if_addr_i = '0;
    ld_req_i = 1'b0;
    ld_i = '0;
    st_req_i = 1'b0;
    st_i = '0;
    ar_ready_i = 1'b0;
    r_i = '0;
    r_valid_i = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i = 1'b0;
    b_i = '0;
    b_valid_i = 1'b0;
    // fill depends on the whole byte address of each word
    for (int i = 0; i < 256; i++)
      mem_q[i] = {32'(i * 8 + 4) ^ 32'h5A5A_0000, 32'(i * 8) ^ 32'h5A5A_0000};
    void'($urandom(4));
    // slaves inherit their random state from this seeded thread
    fork
      serve_reads();
      serve_writes();
    join_none
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    foreach (stim[i])
      run_entry(stim[i]);
    race_requests();
    repeat (4) @(posedge clk);
    check_count("if_rvalid_o pulses", if_cnt, exp_if);
    check_count("ld_rvalid_o pulses", ld_cnt, exp_ld);
    check_count("st_done_o pulses", st_cnt, exp_st);
    if (dut_i.sva_i.fail_cnt == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      abort_run("AXI protocol assertions failed during the run");
  end

endmodule

//--- mem_bus_top.f
rtl/mem_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/store_align.sv
rtl/load_return.sv
rtl/clint_timer.sv
rtl/mem_bus_top.sv
test/mem_bus_sva.sv
test/mem_bus_tb.sv
